// File: list.f
+incdir+hdl
hdl/unicore_pkg.sv
hdl/two_fifo.sv
hdl/cmd_router.sv
hdl/resp_router.sv
hdl/loopback.sv
hdl/unicore_mem_top.sv
tests/tb_clk_gen.sv
tests/tb_checker.sv
tests/tb_unicore.sv

// File: Bender.yml
package:
  name: unicore_mem

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/unicore_pkg.sv
      - hdl/two_fifo.sv
      - hdl/cmd_router.sv
      - hdl/resp_router.sv
      - hdl/loopback.sv
      - hdl/unicore_mem_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_checker.sv
      - tests/tb_unicore.sv

// File: tests/tb_unicore.sv
`timescale 1ns/1ps
`default_nettype none

`include "unicore_cfg.svh"

// Memory or I/O side, answers in order after a random delay
module tb_responder
  (  input  wire                        clk_i
   , input  wire                        rst_n_i
   , input  wire unicore_pkg::mem_msg_s cmd_i
   , input  wire                        cmd_v_i
   , output logic                       cmd_ready_o
   , output unicore_pkg::mem_msg_s      resp_o
   , output logic                       resp_v_o
   , input  wire                        resp_ready_i
   );

  unicore_pkg::mem_msg_s pend[$];
  int                    due[$];
  unicore_pkg::mem_msg_s rsp;
  int                    cyc;

  initial
  begin
    cmd_ready_o <= 1'b0;
    resp_o      <= '0;
    resp_v_o    <= 1'b0;
    cyc          = 0;
  end

  always @(posedge clk_i)
  begin
    cyc++;
    if (rst_n_i)
    begin
      if (resp_v_o && resp_ready_i)
      begin
        pend.delete(0);
        due.delete(0);
      end
      if (cmd_v_i && cmd_ready_o)
      begin
        rsp.header = cmd_i.header;
        rsp.data   = ~64'(cmd_i.header.addr);
        pend.push_back(rsp);
        due.push_back(cyc + int'($urandom % 6));
      end
      cmd_ready_o <= (($urandom % 4) != 0);
      if ((pend.size() > 0) && (due[0] <= cyc))
      begin
        resp_o   <= pend[0];
        resp_v_o <= 1'b1;
      end
      else
        resp_v_o <= 1'b0;
    end
  end

endmodule

module tb_unicore;

  localparam int NumCmds   = 60;
  localparam int WaitLimit = 20000;

  logic clk;
  logic rst_n;

  unicore_pkg::mem_msg_s [`UNICORE_NUM_REQ-1:0] req_cmd;
  logic [`UNICORE_NUM_REQ-1:0]                  req_cmd_v;
  logic [`UNICORE_NUM_REQ-1:0]                  req_cmd_ready;
  unicore_pkg::mem_msg_s [`UNICORE_NUM_REQ-1:0] req_resp;
  logic [`UNICORE_NUM_REQ-1:0]                  req_resp_v;
  logic [`UNICORE_NUM_REQ-1:0]                  req_resp_ready;

  unicore_pkg::mem_msg_s io_cmd;
  unicore_pkg::mem_msg_s io_resp;
  unicore_pkg::mem_msg_s mem_cmd;
  unicore_pkg::mem_msg_s mem_resp;
  logic                  io_cmd_v;
  logic                  io_cmd_ready;
  logic                  io_resp_v;
  logic                  io_resp_ready;
  logic                  mem_cmd_v;
  logic                  mem_cmd_ready;
  logic                  mem_resp_v;
  logic                  mem_resp_ready;

  int sent [`UNICORE_NUM_REQ];
  int total_sent;
  int pending;
  int timeouts;
  int total_errs;
  int wait_cyc;
  int seed;

  // Address windows: local devices, DRAM, other domains
  function automatic unicore_pkg::mem_msg_s rand_cmd(int req);
    unicore_pkg::mem_msg_s      cmd;
    logic [`UNICORE_ADDR_W-1:0] addr;
    addr = {8'($urandom), 32'($urandom)};
    case ($urandom % 4)
      0, 1:
      begin
        addr[39:31] = '0;
        addr[23:20] = 4'($urandom % 8);
      end
      2:
      begin
        addr[39:37] = '0;
        addr[31]    = 1'b1;
      end
      default:
        addr[39:37] = 3'(1 + $urandom % 7);
    endcase
    cmd.header.msg_type = unicore_pkg::msg_type_e'($urandom % 4);
    cmd.header.addr     = addr;
    cmd.header.size     = 3'($urandom);
    cmd.header.lce_id   = req[1:0];
    cmd.data            = {$urandom, $urandom};
    return cmd;
  endfunction

  tb_clk_gen i_clk_gen
    (.clk_o   (clk)
    ,.rst_n_o (rst_n)
    );

  unicore_mem_top i_dut
    (.clk_i            (clk)
    ,.rst_n_i          (rst_n)
    ,.req_cmd_i        (req_cmd)
    ,.req_cmd_v_i      (req_cmd_v)
    ,.req_cmd_ready_o  (req_cmd_ready)
    ,.req_resp_o       (req_resp)
    ,.req_resp_v_o     (req_resp_v)
    ,.req_resp_ready_i (req_resp_ready)
    ,.io_cmd_o         (io_cmd)
    ,.io_cmd_v_o       (io_cmd_v)
    ,.io_cmd_ready_i   (io_cmd_ready)
    ,.io_resp_i        (io_resp)
    ,.io_resp_v_i      (io_resp_v)
    ,.io_resp_ready_o  (io_resp_ready)
    ,.mem_cmd_o        (mem_cmd)
    ,.mem_cmd_v_o      (mem_cmd_v)
    ,.mem_cmd_ready_i  (mem_cmd_ready)
    ,.mem_resp_i       (mem_resp)
    ,.mem_resp_v_i     (mem_resp_v)
    ,.mem_resp_ready_o (mem_resp_ready)
    );

  tb_responder i_io_resp
    (.clk_i        (clk)
    ,.rst_n_i      (rst_n)
    ,.cmd_i        (io_cmd)
    ,.cmd_v_i      (io_cmd_v)
    ,.cmd_ready_o  (io_cmd_ready)
    ,.resp_o       (io_resp)
    ,.resp_v_o     (io_resp_v)
    ,.resp_ready_i (io_resp_ready)
    );

  tb_responder i_mem_resp
    (.clk_i        (clk)
    ,.rst_n_i      (rst_n)
    ,.cmd_i        (mem_cmd)
    ,.cmd_v_i      (mem_cmd_v)
    ,.cmd_ready_o  (mem_cmd_ready)
    ,.resp_o       (mem_resp)
    ,.resp_v_o     (mem_resp_v)
    ,.resp_ready_i (mem_resp_ready)
    );

  tb_checker i_checker
    (.clk_i            (clk)
    ,.rst_n_i          (rst_n)
    ,.req_cmd_i        (req_cmd)
    ,.req_cmd_v_i      (req_cmd_v)
    ,.req_cmd_ready_i  (req_cmd_ready)
    ,.req_resp_i       (req_resp)
    ,.req_resp_v_i     (req_resp_v)
    ,.req_resp_ready_i (req_resp_ready)
    ,.io_cmd_i         (io_cmd)
    ,.io_cmd_v_i       (io_cmd_v)
    ,.io_cmd_ready_i   (io_cmd_ready)
    ,.mem_cmd_i        (mem_cmd)
    ,.mem_cmd_v_i      (mem_cmd_v)
    ,.mem_cmd_ready_i  (mem_cmd_ready)
    ,.pending_o        (pending)
    );

  always @(posedge clk)
  begin
    if (rst_n)
    begin
      for (int r = 0; r < `UNICORE_NUM_REQ; r++)
      begin
        if (req_cmd_v[r] && req_cmd_ready[r])
        begin
          sent[r]++;
          total_sent++;
        end
        // A command stays on the port until it is taken
        if (!req_cmd_v[r] || req_cmd_ready[r])
        begin
          if ((sent[r] < NumCmds) && (($urandom % 3) != 0))
          begin
            req_cmd[r]   <= rand_cmd(r);
            req_cmd_v[r] <= 1'b1;
          end
          else
            req_cmd_v[r] <= 1'b0;
        end
      end
      req_resp_ready <= 3'($urandom);
    end
  end

  initial
  begin
    seed = 76764;
    void'($urandom(seed));
    req_cmd        <= '0;
    req_cmd_v      <= '0;
    req_resp_ready <= '0;
    for (int r = 0; r < `UNICORE_NUM_REQ; r++)
      sent[r] = 0;
    total_sent = 0;
    timeouts   = 0;

    wait_cyc = 0;
    while ((rst_n !== 1'b1) && (wait_cyc < 20))
    begin
      @(posedge clk);
      wait_cyc++;
    end
    if (rst_n !== 1'b1)
    begin
      $display("timeout: reset was never released");
      timeouts++;
    end

    wait_cyc = 0;
    do
    begin
      @(posedge clk);
      wait_cyc++;
    end
    while (((total_sent < NumCmds * `UNICORE_NUM_REQ) || (req_cmd_v != '0))
           && (wait_cyc < WaitLimit));
    if (wait_cyc >= WaitLimit)
    begin
      $display("timeout: requesters could not get all their commands accepted");
      timeouts++;
    end

    // One more edge so the checker has seen the last accepted command
    wait_cyc = 0;
    do
    begin
      @(posedge clk);
      wait_cyc++;
    end
    while ((pending != 0) && (wait_cyc < WaitLimit));
    if (pending != 0)
    begin
      $display("timeout: %0d responses still outstanding", pending);
      timeouts++;
    end

    i_checker.end_checks(timeouts, total_errs);
    if (total_errs == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "unicore_cfg.svh"

module tb_checker
  (  input  wire                                               clk_i
   , input  wire                                               rst_n_i
   , input  wire unicore_pkg::mem_msg_s [`UNICORE_NUM_REQ-1:0] req_cmd_i
   , input  wire [`UNICORE_NUM_REQ-1:0]                        req_cmd_v_i
   , input  wire [`UNICORE_NUM_REQ-1:0]                        req_cmd_ready_i
   , input  wire unicore_pkg::mem_msg_s [`UNICORE_NUM_REQ-1:0] req_resp_i
   , input  wire [`UNICORE_NUM_REQ-1:0]                        req_resp_v_i
   , input  wire [`UNICORE_NUM_REQ-1:0]                        req_resp_ready_i
   , input  wire unicore_pkg::mem_msg_s                        io_cmd_i
   , input  wire                                               io_cmd_v_i
   , input  wire                                               io_cmd_ready_i
   , input  wire unicore_pkg::mem_msg_s                        mem_cmd_i
   , input  wire                                               mem_cmd_v_i
   , input  wire                                               mem_cmd_ready_i
   , output int                                                pending_o
   );

  localparam int DestIo  = 0;
  localparam int DestMem = 1;
  localparam int DestLb  = 2;

  // Commands due at io or mem with their destination kept alongside
  unicore_pkg::mem_msg_s exp_cmd[$];
  int                    exp_dst[$];
  unicore_pkg::mem_msg_s exp_rsp[$];

  int accepted [`UNICORE_NUM_REQ];
  int answered [`UNICORE_NUM_REQ];
  int value_errs;
  int other_errs;
  bit seen_accept;

  initial
  begin
    for (int r = 0; r < `UNICORE_NUM_REQ; r++)
    begin
      accepted[r] = 0;
      answered[r] = 0;
    end
    value_errs  = 0;
    other_errs  = 0;
    seen_accept = 1'b0;
    pending_o  <= 0;
  end

  // Domain in bits 39:37 and device in bits 23:20
  function automatic int dest_of(logic [`UNICORE_ADDR_W-1:0] addr);
    logic       local_addr;
    logic [3:0] dev;
    local_addr = (addr < `UNICORE_DRAM_BASE);
    dev        = addr[23:20];
    if (addr[39:37] != 3'd0)
      return DestIo;
    if (local_addr && ((dev == `UNICORE_DEV_BOOT) || (dev == `UNICORE_DEV_HOST)))
      return DestIo;
    if (!local_addr || (dev == `UNICORE_DEV_CACHE))
      return DestMem;
    return DestLb;
  endfunction

  function automatic unicore_pkg::mem_msg_s resp_of(unicore_pkg::mem_msg_s cmd);
    unicore_pkg::mem_msg_s rsp;
    rsp.header = cmd.header;
    if (dest_of(cmd.header.addr) != DestLb)
      rsp.data = ~64'(cmd.header.addr);
    else if ((cmd.header.msg_type == unicore_pkg::e_mem_rd)
             || (cmd.header.msg_type == unicore_pkg::e_mem_uc_rd))
      rsp.data = '0;
    else
      rsp.data = cmd.data;
    return rsp;
  endfunction

  // Oldest outstanding command of the same requester for this destination
  task automatic match_cmd(input string name, input int dest, input unicore_pkg::mem_msg_s act);
    int idx;
    idx = -1;
    for (int i = 0; i < exp_cmd.size(); i++)
    begin
      if ((idx < 0) && (exp_dst[i] == dest) && (exp_cmd[i].header.lce_id == act.header.lce_id))
        idx = i;
    end
    if (idx < 0)
    begin
      $display("%s carried a command from requester %0d that was not routed there",
               name, act.header.lce_id);
      other_errs++;
    end
    else
    begin
      if (act !== exp_cmd[idx])
      begin
        $display("FAIL %s exp=%h act=%h", name, exp_cmd[idx], act);
        value_errs++;
      end
      exp_cmd.delete(idx);
      exp_dst.delete(idx);
    end
  endtask

  // Responses from different destinations may pass each other
  task automatic match_resp(input int port, input unicore_pkg::mem_msg_s act);
    int idx;
    idx = -1;
    answered[port]++;
    if (act.header.lce_id != port)
    begin
      $display("FAIL req_resp_o[%0d].lce_id exp=%h act=%h", port, port, act.header.lce_id);
      value_errs++;
    end
    for (int i = 0; i < exp_rsp.size(); i++)
    begin
      if ((idx < 0) && (exp_rsp[i] === act))
        idx = i;
    end
    if (idx < 0)
    begin
      $display("req_resp_o[%0d] returned %h, which matches no outstanding response", port, act);
      other_errs++;
    end
    else
      exp_rsp.delete(idx);
  endtask

  task automatic end_checks(input int timeouts, output int total);
    for (int r = 0; r < `UNICORE_NUM_REQ; r++)
    begin
      if (answered[r] != accepted[r])
      begin
        $display("FAIL responses[%0d] exp=%h act=%h", r, accepted[r], answered[r]);
        value_errs++;
      end
    end
    if (exp_cmd.size() != 0)
    begin
      $display("%0d commands never reached io or mem", exp_cmd.size());
      other_errs++;
    end
    if (exp_rsp.size() != 0)
    begin
      $display("%0d responses never came back", exp_rsp.size());
      other_errs++;
    end
    $display("errors: value %0d, other %0d, timeout %0d", value_errs, other_errs, timeouts);
    total = value_errs + other_errs + timeouts;
  endtask

  always @(posedge clk_i)
  begin
    if (!seen_accept && ({io_cmd_v_i, mem_cmd_v_i, req_resp_v_i} != '0))
    begin
      $display("FAIL {io_cmd_v_o,mem_cmd_v_o,req_resp_v_o} exp=%h act=%h",
               5'h0, {io_cmd_v_i, mem_cmd_v_i, req_resp_v_i});
      value_errs++;
    end
    if (rst_n_i)
    begin
      for (int r = 0; r < `UNICORE_NUM_REQ; r++)
      begin
        if (req_cmd_v_i[r] && req_cmd_ready_i[r])
        begin
          seen_accept = 1'b1;
          accepted[r]++;
          exp_rsp.push_back(resp_of(req_cmd_i[r]));
          if (dest_of(req_cmd_i[r].header.addr) != DestLb)
          begin
            exp_cmd.push_back(req_cmd_i[r]);
            exp_dst.push_back(dest_of(req_cmd_i[r].header.addr));
          end
        end
      end
      if (io_cmd_v_i && io_cmd_ready_i)
        match_cmd("io_cmd_o", DestIo, io_cmd_i);
      if (mem_cmd_v_i && mem_cmd_ready_i)
        match_cmd("mem_cmd_o", DestMem, mem_cmd_i);
      for (int r = 0; r < `UNICORE_NUM_REQ; r++)
      begin
        if (req_resp_v_i[r] && req_resp_ready_i[r])
          match_resp(r, req_resp_i[r]);
      end
    end
    pending_o <= exp_rsp.size();
  end

endmodule

`default_nettype wire

// File: tests/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen
  (  output logic clk_o
   , output logic rst_n_o
   );

  initial
  begin
    clk_o = 1'b0;
    forever
      #50 clk_o = ~clk_o;
  end

  // Reset held through five rising edges
  initial
  begin
    rst_n_o = 1'b0;
    repeat (5)
      @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// File: hdl/unicore_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "unicore_cfg.svh"

module unicore_mem_top
  (  input  wire                                        clk_i
   , input  wire                                        rst_n_i

   // Requester ports: icache engine, dcache engine, incoming I/O
   , input  wire unicore_pkg::mem_msg_s [`UNICORE_NUM_REQ-1:0] req_cmd_i
   , input  wire [`UNICORE_NUM_REQ-1:0]                 req_cmd_v_i
   , output logic [`UNICORE_NUM_REQ-1:0]                req_cmd_ready_o

   , output unicore_pkg::mem_msg_s [`UNICORE_NUM_REQ-1:0] req_resp_o
   , output logic [`UNICORE_NUM_REQ-1:0]                req_resp_v_o
   , input  wire [`UNICORE_NUM_REQ-1:0]                 req_resp_ready_i

   // Outgoing I/O
   , output unicore_pkg::mem_msg_s                      io_cmd_o
   , output logic                                       io_cmd_v_o
   , input  wire                                        io_cmd_ready_i

   , input  wire unicore_pkg::mem_msg_s                 io_resp_i
   , input  wire                                        io_resp_v_i
   , output logic                                       io_resp_ready_o

   // Toward DRAM
   , output unicore_pkg::mem_msg_s                      mem_cmd_o
   , output logic                                       mem_cmd_v_o
   , input  wire                                        mem_cmd_ready_i

   , input  wire unicore_pkg::mem_msg_s                 mem_resp_i
   , input  wire                                        mem_resp_v_i
   , output logic                                       mem_resp_ready_o
   );

  unicore_pkg::mem_msg_s [`UNICORE_NUM_REQ-1:0] cmd_head;
  logic [`UNICORE_NUM_REQ-1:0]                  cmd_head_v;
  logic [`UNICORE_NUM_REQ-1:0]                  cmd_yumi;

  unicore_pkg::mem_msg_s                        resp_q_data;
  logic [`UNICORE_NUM_REQ-1:0]                  resp_q_v;
  logic [`UNICORE_NUM_REQ-1:0]                  resp_q_ready;
  logic [`UNICORE_NUM_REQ-1:0]                  resp_yumi;

  unicore_pkg::mem_msg_s lb_cmd;
  logic                  lb_cmd_v;
  logic                  lb_cmd_ready;
  unicore_pkg::mem_msg_s lb_resp;
  logic                  lb_resp_v;
  logic                  lb_resp_yumi;

  // Response ports leave the tile as valid/ready
  assign resp_yumi = req_resp_ready_i & req_resp_v_o;

  for (genvar i = 0; i < `UNICORE_NUM_REQ; i++)
  begin : g_fifo
    two_fifo cmd_fifo
      (.clk_i   (clk_i)
      ,.rst_n_i (rst_n_i)
      ,.data_i  (req_cmd_i[i])
      ,.v_i     (req_cmd_v_i[i])
      ,.ready_o (req_cmd_ready_o[i])
      ,.data_o  (cmd_head[i])
      ,.v_o     (cmd_head_v[i])
      ,.yumi_i  (cmd_yumi[i])
      );

    two_fifo resp_fifo
      (.clk_i   (clk_i)
      ,.rst_n_i (rst_n_i)
      ,.data_i  (resp_q_data)
      ,.v_i     (resp_q_v[i])
      ,.ready_o (resp_q_ready[i])
      ,.data_o  (req_resp_o[i])
      ,.v_o     (req_resp_v_o[i])
      ,.yumi_i  (resp_yumi[i])
      );
  end

  cmd_router i_cmd_router
    (.head_i          (cmd_head)
    ,.head_v_i        (cmd_head_v)
    ,.yumi_o          (cmd_yumi)
    ,.io_cmd_o        (io_cmd_o)
    ,.io_cmd_v_o      (io_cmd_v_o)
    ,.io_cmd_ready_i  (io_cmd_ready_i)
    ,.mem_cmd_o       (mem_cmd_o)
    ,.mem_cmd_v_o     (mem_cmd_v_o)
    ,.mem_cmd_ready_i (mem_cmd_ready_i)
    ,.lb_cmd_o        (lb_cmd)
    ,.lb_cmd_v_o      (lb_cmd_v)
    ,.lb_cmd_ready_i  (lb_cmd_ready)
    );

  loopback i_loopback
    (.clk_i       (clk_i)
    ,.rst_n_i     (rst_n_i)
    ,.cmd_i       (lb_cmd)
    ,.cmd_v_i     (lb_cmd_v)
    ,.cmd_ready_o (lb_cmd_ready)
    ,.resp_o      (lb_resp)
    ,.resp_v_o    (lb_resp_v)
    ,.resp_yumi_i (lb_resp_yumi)
    );

  resp_router i_resp_router
    (.lb_resp_i        (lb_resp)
    ,.lb_resp_v_i      (lb_resp_v)
    ,.lb_resp_yumi_o   (lb_resp_yumi)
    ,.mem_resp_i       (mem_resp_i)
    ,.mem_resp_v_i     (mem_resp_v_i)
    ,.mem_resp_ready_o (mem_resp_ready_o)
    ,.io_resp_i        (io_resp_i)
    ,.io_resp_v_i      (io_resp_v_i)
    ,.io_resp_ready_o  (io_resp_ready_o)
    ,.q_data_o         (resp_q_data)
    ,.q_v_o            (resp_q_v)
    ,.q_ready_i        (resp_q_ready)
    );

endmodule

`default_nettype wire

// File: hdl/loopback.sv
`timescale 1ns/1ps
`default_nettype none

module loopback
  (  input  wire                      clk_i
   , input  wire                      rst_n_i

   , input  wire unicore_pkg::mem_msg_s cmd_i
   , input  wire                      cmd_v_i
   , output logic                     cmd_ready_o

   , output unicore_pkg::mem_msg_s    resp_o
   , output logic                     resp_v_o
   , input  wire                      resp_yumi_i
   );

  unicore_pkg::mem_msg_s resp_r;

  logic full_r;
  logic take;
  logic is_read;

  assign cmd_ready_o = ~full_r;
  assign take        = cmd_v_i & cmd_ready_o;
  assign is_read     = (cmd_i.header.msg_type == unicore_pkg::e_mem_rd)
                     | (cmd_i.header.msg_type == unicore_pkg::e_mem_uc_rd);

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      full_r <= 1'b0;
    else if (take)
      full_r <= 1'b1;
    else if (resp_yumi_i)
      full_r <= 1'b0;
  end

  // Reads of unmapped space return zero
  always_ff @(posedge clk_i)
  begin
    if (take)
    begin
      resp_r.header <= cmd_i.header;
      resp_r.data   <= is_read ? '0 : cmd_i.data;
    end
  end

  assign resp_o   = resp_r;
  assign resp_v_o = full_r;

endmodule

`default_nettype wire

// File: hdl/resp_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "unicore_cfg.svh"

module resp_router
  (  input  wire unicore_pkg::mem_msg_s lb_resp_i
   , input  wire                      lb_resp_v_i
   , output logic                     lb_resp_yumi_o

   , input  wire unicore_pkg::mem_msg_s mem_resp_i
   , input  wire                      mem_resp_v_i
   , output logic                     mem_resp_ready_o

   , input  wire unicore_pkg::mem_msg_s io_resp_i
   , input  wire                      io_resp_v_i
   , output logic                     io_resp_ready_o

   , output unicore_pkg::mem_msg_s    q_data_o
   , output logic [`UNICORE_NUM_REQ-1:0] q_v_o
   , input  wire [`UNICORE_NUM_REQ-1:0]  q_ready_i
   );

  logic all_ready;
  logic mem_grant;
  logic io_grant;
  logic any_grant;

  // Every response queue must have room, whoever the target is
  assign all_ready = &q_ready_i;

  // Loopback, then memory, then I/O
  assign lb_resp_yumi_o   = all_ready & lb_resp_v_i;
  assign mem_resp_ready_o = all_ready & ~lb_resp_v_i;
  assign io_resp_ready_o  = all_ready & ~lb_resp_v_i & ~mem_resp_v_i;

  assign mem_grant = mem_resp_ready_o & mem_resp_v_i;
  assign io_grant  = io_resp_ready_o & io_resp_v_i;
  assign any_grant = lb_resp_yumi_o | mem_grant | io_grant;

  always_comb
  begin
    if (lb_resp_v_i)
      q_data_o = lb_resp_i;
    else if (mem_resp_v_i)
      q_data_o = mem_resp_i;
    else
      q_data_o = io_resp_i;
  end

  // Steer by requester id
  for (genvar i = 0; i < `UNICORE_NUM_REQ; i++)
  begin : g_steer
    localparam logic [`UNICORE_LCE_ID_W-1:0] LceId = i;

    assign q_v_o[i] = any_grant & (q_data_o.header.lce_id == LceId);
  end

endmodule

`default_nettype wire

// File: hdl/cmd_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "unicore_cfg.svh"

module cmd_router
  (  input  wire unicore_pkg::mem_msg_s [`UNICORE_NUM_REQ-1:0] head_i
   , input  wire [`UNICORE_NUM_REQ-1:0]               head_v_i
   , output logic [`UNICORE_NUM_REQ-1:0]              yumi_o

   , output unicore_pkg::mem_msg_s                    io_cmd_o
   , output logic                                     io_cmd_v_o
   , input  wire                                      io_cmd_ready_i

   , output unicore_pkg::mem_msg_s                    mem_cmd_o
   , output logic                                     mem_cmd_v_o
   , input  wire                                      mem_cmd_ready_i

   , output unicore_pkg::mem_msg_s                    lb_cmd_o
   , output logic                                     lb_cmd_v_o
   , input  wire                                      lb_cmd_ready_i
   );

  unicore_pkg::mem_msg_s sel_msg;
  unicore_pkg::paddr_u   sel_addr;

  logic                      all_ready;
  logic                      any_grant;
  logic                      local_cmd;
  logic                      other_domain;
  logic [`UNICORE_DEV_W-1:0] dev;
  logic                      is_io;
  logic                      is_mem;
  logic                      is_lb;

  // A stalled destination blocks every requester
  assign all_ready = io_cmd_ready_i & mem_cmd_ready_i & lb_cmd_ready_i;

  always_comb
  begin
    yumi_o = '0;
    if (all_ready)
    begin
      for (int i = 0; i < `UNICORE_NUM_REQ; i++)
      begin
        if (head_v_i[i] && (yumi_o == '0))
          yumi_o[i] = 1'b1;
      end
    end
  end

  always_comb
  begin
    sel_msg = '0;
    for (int i = 0; i < `UNICORE_NUM_REQ; i++)
    begin
      if (yumi_o[i])
        sel_msg = head_i[i];
    end
  end

  assign any_grant = |yumi_o;

  // Address map
  assign sel_addr.raw = sel_msg.header.addr;
  assign local_cmd    = (sel_addr.raw < `UNICORE_DRAM_BASE);
  assign dev          = sel_addr.loc.dev;
  assign other_domain = (sel_addr.loc.did != '0);

  assign is_io  = (local_cmd & ((dev == `UNICORE_DEV_BOOT) | (dev == `UNICORE_DEV_HOST)))
                | other_domain;
  // Other domains also sit above the DRAM base so I/O claims them first
  assign is_mem = ~is_io & (~local_cmd | (dev == `UNICORE_DEV_CACHE));
  assign is_lb  = ~is_io & ~is_mem;

  assign io_cmd_o  = sel_msg;
  assign mem_cmd_o = sel_msg;
  assign lb_cmd_o  = sel_msg;

  assign io_cmd_v_o  = any_grant & is_io;
  assign mem_cmd_v_o = any_grant & is_mem;
  assign lb_cmd_v_o  = any_grant & is_lb;

endmodule

`default_nettype wire

// File: hdl/two_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module two_fifo
  (  input  wire                      clk_i
   , input  wire                      rst_n_i

   , input  wire unicore_pkg::mem_msg_s data_i
   , input  wire                      v_i
   , output logic                     ready_o

   , output unicore_pkg::mem_msg_s    data_o
   , output logic                     v_o
   , input  wire                      yumi_i
   );

  unicore_pkg::mem_msg_s mem_r [2];

  logic wr_ptr_r;
  logic rd_ptr_r;
  logic full_r;
  logic enq;
  logic deq;

  assign enq = v_i & ready_o;
  assign deq = yumi_i;

  assign ready_o = ~full_r;
  // Empty when pointers meet and not full
  assign v_o     = full_r | (wr_ptr_r != rd_ptr_r);
  assign data_o  = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      full_r   <= 1'b0;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= ~wr_ptr_r;
      if (deq)
        rd_ptr_r <= ~rd_ptr_r;

      if (full_r)
        full_r <= ~deq;
      else
        full_r <= enq & ~deq & (wr_ptr_r != rd_ptr_r);  // second entry lands
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
      mem_r[wr_ptr_r] <= data_i;
  end

endmodule

`default_nettype wire

// File: hdl/unicore_pkg.sv
`default_nettype none

`include "unicore_cfg.svh"

package unicore_pkg;

  typedef enum logic [1:0]
  {
    e_mem_rd    = 2'b00
    , e_mem_wr    = 2'b01
    , e_mem_uc_rd = 2'b10
    , e_mem_uc_wr = 2'b11
  } msg_type_e;

  typedef struct packed
  {
    msg_type_e                    msg_type;
    logic [`UNICORE_ADDR_W-1:0]   addr;
    logic [`UNICORE_SIZE_W-1:0]   size;
    logic [`UNICORE_LCE_ID_W-1:0] lce_id;
  } mem_header_s;

  typedef struct packed
  {
    mem_header_s                header;
    logic [`UNICORE_DATA_W-1:0] data;
  } mem_msg_s;

  // Local window split: domain, unused upper bits, device, offset
  typedef struct packed
  {
    logic [`UNICORE_DID_W-1:0]    did;
    logic [`UNICORE_ADDR_W-`UNICORE_DID_W-`UNICORE_DEV_W-`UNICORE_OFFSET_W-1:0] upper;
    logic [`UNICORE_DEV_W-1:0]    dev;
    logic [`UNICORE_OFFSET_W-1:0] offset;
  } paddr_local_s;

  typedef union packed
  {
    logic [`UNICORE_ADDR_W-1:0] raw;
    paddr_local_s               loc;
  } paddr_u;

endpackage

`default_nettype wire

// File: hdl/unicore_cfg.svh
`ifndef UNICORE_CFG_SVH
`define UNICORE_CFG_SVH

// Message field widths
`define UNICORE_ADDR_W     40
`define UNICORE_DATA_W     64
`define UNICORE_LCE_ID_W   2
`define UNICORE_SIZE_W     3

// Requesters: icache engine, dcache engine, incoming I/O
`define UNICORE_NUM_REQ    3

// Local address map
`define UNICORE_DID_W      3
`define UNICORE_DEV_W      4
`define UNICORE_OFFSET_W   20
`define UNICORE_DRAM_BASE  40'h00_8000_0000

`define UNICORE_DEV_BOOT   4'd0
`define UNICORE_DEV_HOST   4'd1
`define UNICORE_DEV_CACHE  4'd4

`endif
